// ==== design/game_cfg.svh ====
`ifndef GAME_CFG_SVH
`define GAME_CFG_SVH

// playing field in grid cells
`define FIELD_WIDTH 60
`define FIELD_HEIGHT 45

// side of the square tank and target box
`define TANK_SIZE 3

// table sizes
`define MAX_BULLETS 8
`define MAX_TARGETS 4

// default clock cycles between bullet advances
`define BULLET_TICK_CYCLES 200

// BCD digits in the score
`define SCORE_DIGITS 4

`endif

// ==== design/grid_pkg.sv ====
`default_nettype none

package grid_pkg;

    // one grid coordinate, x or y
    typedef logic [9:0] coord_t;

    // facing and travel direction
    typedef enum logic [1:0] {
        dir_left  = 2'b00,
        dir_right = 2'b01,
        dir_up    = 2'b10,
        dir_down  = 2'b11
    } dir_t;

endpackage

`default_nettype wire

// ==== design/bullet_pkg.sv ====
`default_nettype none

package bullet_pkg;

    // index into the bullet table
    typedef logic [2:0] slot_t;

    // free slots held by the launcher
    typedef logic [3:0] credit_t;

    // who may use the bullet table in a cycle
    typedef enum logic {
        req_launcher = 1'b0,
        req_stepper  = 1'b1
    } requester_t;

endpackage

`default_nettype wire

// ==== design/player_tank.sv ====
`default_nettype none
`timescale 1ns/1ps
`include "game_cfg.svh"

module player_tank
    import grid_pkg::*;
    import bullet_pkg::*;
(
    input  wire         clk_100mhz,
    input  wire         rst,
    input  wire         press,
    input  wire         move_btn,
    input  wire         shoot_btn,
    input  wire dir_t   dir_in,
    input  wire         credit_ret,
    input  wire         wr_gnt,
    output logic        running,
    output coord_t      player_x,
    output coord_t      player_y,
    output dir_t        player_dir,
    output logic        wr_req,
    output coord_t      wr_x,
    output coord_t      wr_y,
    output dir_t        wr_dir
);

    // bit 0 press, bit 1 move, bit 2 shoot
    logic [2:0] btn_s0;
    logic [2:0] btn_s1;
    logic [2:0] btn_s2;
    logic [2:0] btn_edge;
    dir_t       dir_s0;
    dir_t       dir_s1;
    credit_t    credits;
    coord_t     muzzle_x;
    coord_t     muzzle_y;
    logic       muzzle_ok;
    logic       spend;

    // two-flop synchronizer, then a registered rising edge
    always_ff @(posedge clk_100mhz) begin
        if (rst) begin
            btn_s0   <= '0;
            btn_s1   <= '0;
            btn_s2   <= '0;
            btn_edge <= '0;
            dir_s0   <= dir_right;
            dir_s1   <= dir_right;
        end else begin
            btn_s0   <= {shoot_btn, move_btn, press};
            btn_s1   <= btn_s0;
            btn_s2   <= btn_s1;
            btn_edge <= btn_s1 & ~btn_s2;
            dir_s0   <= dir_in;
            dir_s1   <= dir_s0;
        end
    end

    // cell just outside the tank on its facing side
    always_comb begin
        muzzle_x  = player_x + coord_t'(1);
        muzzle_y  = player_y + coord_t'(1);
        muzzle_ok = 1'b0;
        case (player_dir)
            dir_left: begin
                muzzle_x  = player_x - coord_t'(1);
                muzzle_ok = player_x != '0;
            end
            dir_right: begin
                muzzle_x  = player_x + coord_t'(`TANK_SIZE);
                muzzle_ok = player_x + coord_t'(`TANK_SIZE) < coord_t'(`FIELD_WIDTH);
            end
            dir_up: begin
                muzzle_y  = player_y - coord_t'(1);
                muzzle_ok = player_y != '0;
            end
            default: begin
                muzzle_y  = player_y + coord_t'(`TANK_SIZE);
                muzzle_ok = player_y + coord_t'(`TANK_SIZE) < coord_t'(`FIELD_HEIGHT);
            end
        endcase
    end

    assign spend = wr_req & wr_gnt;

    always_ff @(posedge clk_100mhz) begin
        if (rst) begin
            running    <= 1'b0;
            player_x   <= '0;
            player_y   <= '0;
            player_dir <= dir_right;
            wr_req     <= 1'b0;
            wr_x       <= '0;
            wr_y       <= '0;
            wr_dir     <= dir_right;
            credits    <= credit_t'(`MAX_BULLETS);
        end else begin
            if (btn_edge[0]) begin
                running <= 1'b1;
            end

            // turn always, step only if the 3x3 body stays inside
            if (running && btn_edge[1]) begin
                player_dir <= dir_s1;
                case (dir_s1)
                    dir_left:
                        if (player_x != '0) player_x <= player_x - coord_t'(1);
                    dir_right:
                        if (player_x < coord_t'(`FIELD_WIDTH - `TANK_SIZE))
                            player_x <= player_x + coord_t'(1);
                    dir_up:
                        if (player_y != '0) player_y <= player_y - coord_t'(1);
                    default:
                        if (player_y < coord_t'(`FIELD_HEIGHT - `TANK_SIZE))
                            player_y <= player_y + coord_t'(1);
                endcase
            end

            // shots while a request waits or without credit are dropped
            if (spend) begin
                wr_req <= 1'b0;
            end else if (running && btn_edge[2] && !wr_req && credits != '0 && muzzle_ok) begin
                wr_req <= 1'b1;
                wr_x   <= muzzle_x;
                wr_y   <= muzzle_y;
                wr_dir <= player_dir;
            end

            case ({spend, credit_ret})
                2'b10:   credits <= credits - credit_t'(1);
                2'b01:   credits <= credits + credit_t'(1);
                default: credits <= credits;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== design/bullet_store.sv ====
`default_nettype none
`timescale 1ns/1ps
`include "game_cfg.svh"

module bullet_store
    import grid_pkg::*;
    import bullet_pkg::*;
(
    input  wire         clk_100mhz,
    input  wire         rst,
    input  wire         wr_req,
    input  wire coord_t wr_x,
    input  wire coord_t wr_y,
    input  wire dir_t   wr_dir,
    output logic        wr_gnt,
    output slot_t       wr_slot,
    input  wire         rd_req,
    input  wire slot_t  rd_slot,
    output logic        rd_gnt,
    output logic        rd_valid,
    output coord_t      rd_x,
    output coord_t      rd_y,
    output dir_t        rd_dir,
    input  wire         up_req,
    input  wire slot_t  up_slot,
    input  wire coord_t up_x,
    input  wire coord_t up_y,
    input  wire         up_kill,
    output logic [$clog2(`MAX_BULLETS + 1) - 1:0] bullet_count
);

    coord_t                  bx [`MAX_BULLETS];
    coord_t                  by [`MAX_BULLETS];
    dir_t                    bd [`MAX_BULLETS];
    logic [`MAX_BULLETS-1:0] valid;
    logic                    free_any;
    logic                    kill;
    requester_t              winner;

    // lowest free slot
    always_comb begin
        wr_slot  = '0;
        free_any = 1'b0;
        for (int i = `MAX_BULLETS - 1; i >= 0; i--) begin
            if (!valid[i]) begin
                wr_slot  = slot_t'(i);
                free_any = 1'b1;
            end
        end
    end

    // fixed priority, the stepper wins
    assign winner = rd_req ? req_stepper : req_launcher;
    assign rd_gnt = rd_req && winner == req_stepper;
    assign wr_gnt = wr_req && free_any && winner == req_launcher;

    // write-back of the stepper needs no grant
    assign kill = up_req & up_kill;

    always_ff @(posedge clk_100mhz) begin
        if (rst) begin
            valid        <= '0;
            bullet_count <= '0;
            rd_valid     <= 1'b0;
            rd_x         <= '0;
            rd_y         <= '0;
            rd_dir       <= dir_right;
        end else begin
            rd_valid <= rd_gnt & valid[rd_slot];
            if (rd_gnt) begin
                rd_x   <= bx[rd_slot];
                rd_y   <= by[rd_slot];
                rd_dir <= bd[rd_slot];
            end
            if (wr_gnt) valid[wr_slot] <= 1'b1;
            if (kill) valid[up_slot] <= 1'b0;
            case ({wr_gnt, kill})
                2'b10:   bullet_count <= bullet_count + 1'b1;
                2'b01:   bullet_count <= bullet_count - 1'b1;
                default: bullet_count <= bullet_count;
            endcase
        end
    end

    // table contents; a live slot and a free slot never coincide
    always_ff @(posedge clk_100mhz) begin
        if (wr_gnt) begin
            bx[wr_slot] <= wr_x;
            by[wr_slot] <= wr_y;
            bd[wr_slot] <= wr_dir;
        end
        if (up_req && !up_kill) begin
            bx[up_slot] <= up_x;
            by[up_slot] <= up_y;
        end
    end

endmodule

`default_nettype wire

// ==== design/bullet_stepper.sv ====
`default_nettype none
`timescale 1ns/1ps
`include "game_cfg.svh"

module bullet_stepper
    import grid_pkg::*;
    import bullet_pkg::*;
#(
    parameter int TICK_CYCLES = `BULLET_TICK_CYCLES
) (
    input  wire         clk_100mhz,
    input  wire         rst,
    input  wire         running,
    output logic        rd_req,
    output slot_t       rd_slot,
    input  wire         rd_gnt,
    input  wire         rd_valid,
    input  wire coord_t rd_x,
    input  wire coord_t rd_y,
    input  wire dir_t   rd_dir,
    output logic        up_req,
    output slot_t       up_slot,
    output coord_t      up_x,
    output coord_t      up_y,
    output logic        up_kill,
    output logic        credit_ret,
    output logic        hit_probe_valid,
    output coord_t      hit_x,
    output coord_t      hit_y,
    input  wire         hit
);

    logic [$clog2(TICK_CYCLES + 1) - 1:0] tick_cnt;
    logic   tick;
    logic   reading;
    logic   pending;
    slot_t  pend_slot;
    coord_t next_x;
    coord_t next_y;
    logic   leaves;

    assign tick = running && tick_cnt == ($bits(tick_cnt))'(TICK_CYCLES - 1);

    always_ff @(posedge clk_100mhz) begin
        if (rst) begin
            tick_cnt  <= '0;
            reading   <= 1'b0;
            rd_slot   <= '0;
            pending   <= 1'b0;
            pend_slot <= '0;
        end else begin
            if (!running || tick) tick_cnt <= '0;
            else tick_cnt <= tick_cnt + 1'b1;

            // read of slot n+1 overlaps the write-back of slot n
            pending <= rd_req & rd_gnt;
            if (rd_req && rd_gnt) begin
                pend_slot <= rd_slot;
                if (rd_slot == slot_t'(`MAX_BULLETS - 1)) reading <= 1'b0;
                else rd_slot <= rd_slot + slot_t'(1);
            end else if (tick && !reading && !pending) begin
                reading <= 1'b1;
                rd_slot <= '0;
            end
        end
    end

    assign rd_req = reading;

    // next cell, or leave the field
    always_comb begin
        next_x = rd_x;
        next_y = rd_y;
        leaves = 1'b0;
        case (rd_dir)
            dir_left:
                if (rd_x == '0) leaves = 1'b1;
                else next_x = rd_x - coord_t'(1);
            dir_right:
                if (rd_x == coord_t'(`FIELD_WIDTH - 1)) leaves = 1'b1;
                else next_x = rd_x + coord_t'(1);
            dir_up:
                if (rd_y == '0) leaves = 1'b1;
                else next_y = rd_y - coord_t'(1);
            default:
                if (rd_y == coord_t'(`FIELD_HEIGHT - 1)) leaves = 1'b1;
                else next_y = rd_y + coord_t'(1);
        endcase
    end

    // empty slots read back invalid and get no write-back
    assign up_req          = pending & rd_valid;
    assign up_slot         = pend_slot;
    assign up_x            = next_x;
    assign up_y            = next_y;
    assign hit_probe_valid = up_req & ~leaves;
    assign hit_x           = next_x;
    assign hit_y           = next_y;
    assign up_kill         = leaves | (hit_probe_valid & hit);
    // one credit back per deleted bullet
    assign credit_ret      = up_req & up_kill;

endmodule

`default_nettype wire

// ==== design/target_field.sv ====
`default_nettype none
`timescale 1ns/1ps
`include "game_cfg.svh"

module target_field
    import grid_pkg::*;
(
    input  wire         clk_100mhz,
    input  wire         rst,
    input  wire         running,
    input  wire         spawn_valid,
    input  wire coord_t spawn_x,
    input  wire coord_t spawn_y,
    input  wire         hit_probe_valid,
    input  wire coord_t hit_x,
    input  wire coord_t hit_y,
    output logic        hit,
    output logic [$clog2(`MAX_TARGETS + 1) - 1:0] target_count,
    output logic [4*`SCORE_DIGITS - 1:0]          score
);

    localparam int IDX_W = $clog2(`MAX_TARGETS);

    coord_t                  tx [`MAX_TARGETS];
    coord_t                  ty [`MAX_TARGETS];
    logic [`MAX_TARGETS-1:0] tvalid;
    logic [`MAX_TARGETS-1:0] match;
    logic [IDX_W-1:0]        hit_idx;
    logic [IDX_W-1:0]        free_idx;
    logic                    free_any;
    logic                    spawn_ok;
    logic [4*`SCORE_DIGITS - 1:0] score_inc;
    logic                    carry;

    // box test and first match, lowest free slot
    always_comb begin
        hit_idx  = '0;
        free_idx = '0;
        free_any = 1'b0;
        for (int i = `MAX_TARGETS - 1; i >= 0; i--) begin
            match[i] = tvalid[i]
                && hit_x >= tx[i] && hit_x < tx[i] + coord_t'(`TANK_SIZE)
                && hit_y >= ty[i] && hit_y < ty[i] + coord_t'(`TANK_SIZE);
            if (match[i]) hit_idx = IDX_W'(i);
            if (!tvalid[i]) begin
                free_idx = IDX_W'(i);
                free_any = 1'b1;
            end
        end
    end

    assign hit      = hit_probe_valid & (|match);
    assign spawn_ok = running & spawn_valid & free_any;

    // BCD increment; carry out of the top digit means 9999
    always_comb begin
        score_inc = score;
        carry     = 1'b1;
        for (int d = 0; d < `SCORE_DIGITS; d++) begin
            if (carry) begin
                if (score[4*d +: 4] == 4'd9) begin
                    score_inc[4*d +: 4] = 4'd0;
                end else begin
                    score_inc[4*d +: 4] = score[4*d +: 4] + 4'd1;
                    carry = 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk_100mhz) begin
        if (rst) begin
            tvalid       <= '0;
            target_count <= '0;
            score        <= '0;
        end else begin
            if (spawn_ok) tvalid[free_idx] <= 1'b1;
            if (hit) tvalid[hit_idx] <= 1'b0;
            if (hit && !carry) score <= score_inc;
            case ({spawn_ok, hit})
                2'b10:   target_count <= target_count + 1'b1;
                2'b01:   target_count <= target_count - 1'b1;
                default: target_count <= target_count;
            endcase
        end
    end

    always_ff @(posedge clk_100mhz) begin
        if (spawn_ok) begin
            tx[free_idx] <= spawn_x;
            ty[free_idx] <= spawn_y;
        end
    end

endmodule

`default_nettype wire

// ==== design/tank_game_top.sv ====
`default_nettype none
`timescale 1ns/1ps
`include "game_cfg.svh"

module tank_game_top
    import grid_pkg::*;
    import bullet_pkg::*;
#(
    parameter int TICK_CYCLES = `BULLET_TICK_CYCLES
) (
    input  wire         clk_100mhz,
    input  wire         rst,
    input  wire         press,
    input  wire         move_btn,
    input  wire         shoot_btn,
    input  wire dir_t   dir_in,
    input  wire         spawn_valid,
    input  wire coord_t spawn_x,
    input  wire coord_t spawn_y,
    output logic        running,
    output coord_t      player_x,
    output coord_t      player_y,
    output dir_t        player_dir,
    output logic [$clog2(`MAX_BULLETS + 1) - 1:0] bullet_count,
    output logic [$clog2(`MAX_TARGETS + 1) - 1:0] target_count,
    output logic [4*`SCORE_DIGITS - 1:0]          score
);

    // launcher side
    logic   wr_req;
    logic   wr_gnt;
    coord_t wr_x;
    coord_t wr_y;
    dir_t   wr_dir;
    logic   credit_ret;

    // stepper side
    logic   rd_req;
    slot_t  rd_slot;
    logic   rd_gnt;
    logic   rd_valid;
    coord_t rd_x;
    coord_t rd_y;
    dir_t   rd_dir;
    logic   up_req;
    slot_t  up_slot;
    coord_t up_x;
    coord_t up_y;
    logic   up_kill;

    // hit probe
    logic   hit_probe_valid;
    coord_t hit_x;
    coord_t hit_y;
    logic   hit;

    player_tank player_tank_inst (
        .clk_100mhz (clk_100mhz),
        .rst        (rst),
        .press      (press),
        .move_btn   (move_btn),
        .shoot_btn  (shoot_btn),
        .dir_in     (dir_in),
        .credit_ret (credit_ret),
        .wr_gnt     (wr_gnt),
        .running    (running),
        .player_x   (player_x),
        .player_y   (player_y),
        .player_dir (player_dir),
        .wr_req     (wr_req),
        .wr_x       (wr_x),
        .wr_y       (wr_y),
        .wr_dir     (wr_dir)
    );

    bullet_store bullet_store_inst (
        .clk_100mhz   (clk_100mhz),
        .rst          (rst),
        .wr_req       (wr_req),
        .wr_x         (wr_x),
        .wr_y         (wr_y),
        .wr_dir       (wr_dir),
        .wr_gnt       (wr_gnt),
        .wr_slot      (),
        .rd_req       (rd_req),
        .rd_slot      (rd_slot),
        .rd_gnt       (rd_gnt),
        .rd_valid     (rd_valid),
        .rd_x         (rd_x),
        .rd_y         (rd_y),
        .rd_dir       (rd_dir),
        .up_req       (up_req),
        .up_slot      (up_slot),
        .up_x         (up_x),
        .up_y         (up_y),
        .up_kill      (up_kill),
        .bullet_count (bullet_count)
    );

    bullet_stepper #(
        .TICK_CYCLES (TICK_CYCLES)
    ) bullet_stepper_inst (
        .clk_100mhz      (clk_100mhz),
        .rst             (rst),
        .running         (running),
        .rd_req          (rd_req),
        .rd_slot         (rd_slot),
        .rd_gnt          (rd_gnt),
        .rd_valid        (rd_valid),
        .rd_x            (rd_x),
        .rd_y            (rd_y),
        .rd_dir          (rd_dir),
        .up_req          (up_req),
        .up_slot         (up_slot),
        .up_x            (up_x),
        .up_y            (up_y),
        .up_kill         (up_kill),
        .credit_ret      (credit_ret),
        .hit_probe_valid (hit_probe_valid),
        .hit_x           (hit_x),
        .hit_y           (hit_y),
        .hit             (hit)
    );

    target_field target_field_inst (
        .clk_100mhz      (clk_100mhz),
        .rst             (rst),
        .running         (running),
        .spawn_valid     (spawn_valid),
        .spawn_x         (spawn_x),
        .spawn_y         (spawn_y),
        .hit_probe_valid (hit_probe_valid),
        .hit_x           (hit_x),
        .hit_y           (hit_y),
        .hit             (hit),
        .target_count    (target_count),
        .score           (score)
    );

endmodule

`default_nettype wire

// ==== test/tank_game_chk.sv ====
`default_nettype none
`timescale 1ns/1ps
`include "game_cfg.svh"

module tank_game_chk
    import grid_pkg::*;
(
    input  wire         clk_100mhz,
    input  wire         rst,
    input  wire         wr_req,
    input  wire         wr_gnt,
    input  wire         rd_gnt,
    input  wire coord_t wr_x,
    input  wire coord_t wr_y,
    input  wire dir_t   wr_dir,
    input  wire [$clog2(`MAX_BULLETS + 1) - 1:0] bullet_count
);

    // occupancy never above the table size
    count_in_range: assert property (@(posedge clk_100mhz) disable iff (rst)
        bullet_count <= ($bits(bullet_count))'(`MAX_BULLETS))
        else $error("bullet_count above table size");

    // one requester per cycle
    grants_exclusive: assert property (@(posedge clk_100mhz) disable iff (rst)
        !(wr_gnt && rd_gnt))
        else $error("launcher and stepper granted in the same cycle");

    // a waiting launcher request holds its data
    request_held: assert property (@(posedge clk_100mhz) disable iff (rst)
        wr_req && !wr_gnt |=> wr_req && $stable(wr_x) && $stable(wr_y) && $stable(wr_dir))
        else $error("launcher request dropped or changed before its grant");

endmodule

bind bullet_store tank_game_chk tank_game_chk_inst (
    .clk_100mhz   (clk_100mhz),
    .rst          (rst),
    .wr_req       (wr_req),
    .wr_gnt       (wr_gnt),
    .rd_gnt       (rd_gnt),
    .wr_x         (wr_x),
    .wr_y         (wr_y),
    .wr_dir       (wr_dir),
    .bullet_count (bullet_count)
);

`default_nettype wire

// ==== test/tank_game_tb.sv ====
`default_nettype none
`timescale 1ns/1ps
`include "game_cfg.svh"

module tank_game_tb
    import grid_pkg::*;
;

    localparam int TICK = 20;
    localparam int MOVE_CYCLES = 10;
    localparam int FLIGHT_CYCLES = `FIELD_WIDTH * TICK + 50;
    localparam int WATCHDOG_CYCLES = 8 + 60 * MOVE_CYCLES + 12 * FLIGHT_CYCLES + 1000;

    logic clk_100mhz = 1'b0;
    logic rst;
    logic press;
    logic move_btn;
    logic shoot_btn;
    dir_t dir_in;
    logic spawn_valid;
    coord_t spawn_x;
    coord_t spawn_y;
    logic running;
    coord_t player_x;
    coord_t player_y;
    dir_t player_dir;
    logic [$clog2(`MAX_BULLETS + 1) - 1:0] bullet_count;
    logic [$clog2(`MAX_TARGETS + 1) - 1:0] target_count;
    logic [4*`SCORE_DIGITS - 1:0] score;

    // expected state kept by the stimulus
    int ref_x;
    int ref_y;
    logic [1:0] ref_dir;
    int exp_running;
    int exp_bullets;
    int exp_targets;
    int exp_hits;

    logic check_pending = 1'b0;
    int error_count = 0;
    int check_count = 0;
    int test_count = 0;
    int failed_tests = 0;
    int test_errors_at_start;
    string test_name;

    tank_game_top #(
        .TICK_CYCLES (TICK)
    ) tank_game_top_inst (
        .clk_100mhz   (clk_100mhz),
        .rst          (rst),
        .press        (press),
        .move_btn     (move_btn),
        .shoot_btn    (shoot_btn),
        .dir_in       (dir_in),
        .spawn_valid  (spawn_valid),
        .spawn_x      (spawn_x),
        .spawn_y      (spawn_y),
        .running      (running),
        .player_x     (player_x),
        .player_y     (player_y),
        .player_dir   (player_dir),
        .bullet_count (bullet_count),
        .target_count (target_count),
        .score        (score)
    );

    always #5 clk_100mhz = ~clk_100mhz;

    // a move clips at the walls, a shot gives the muzzle cell
    function automatic void ref_step(input int x, input int y, input logic [1:0] d,
                                     input bit shot, output int nx, output int ny);
        nx = x;
        ny = y;
        if (shot) begin
            case (d)
                2'd0: begin
                    nx = x - 1;
                    ny = y + 1;
                end
                2'd1: begin
                    nx = x + `TANK_SIZE;
                    ny = y + 1;
                end
                2'd2: begin
                    nx = x + 1;
                    ny = y - 1;
                end
                default: begin
                    nx = x + 1;
                    ny = y + `TANK_SIZE;
                end
            endcase
        end else begin
            case (d)
                2'd0: if (x > 0) nx = x - 1;
                2'd1: if (x + `TANK_SIZE < `FIELD_WIDTH) nx = x + 1;
                2'd2: if (y > 0) ny = y - 1;
                default: if (y + `TANK_SIZE < `FIELD_HEIGHT) ny = y + 1;
            endcase
        end
    endfunction

    function automatic logic [15:0] to_bcd(input int n);
        logic [15:0] r;
        int v;
        v = (n > 9999) ? 9999 : n;
        r = '0;
        for (int d = 0; d < `SCORE_DIGITS; d++) begin
            r[4*d +: 4] = 4'(v % 10);
            v = v / 10;
        end
        return r;
    endfunction

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        check_count++;
        assert (got === exp) else begin
            $display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
            error_count++;
        end
    endtask

    // outputs are compared at a rising edge, where they are settled
    always @(posedge clk_100mhz) begin
        if (check_pending) begin
            check_value("running", 16'(running), 16'(exp_running));
            check_value("player_x", 16'(player_x), 16'(ref_x));
            check_value("player_y", 16'(player_y), 16'(ref_y));
            check_value("player_dir", 16'(player_dir), 16'(ref_dir));
            check_value("bullet_count", 16'(bullet_count), 16'(exp_bullets));
            check_value("target_count", 16'(target_count), 16'(exp_targets));
            check_value("score", 16'(score), to_bcd(exp_hits));
            check_pending = 1'b0;
        end
    end

    task automatic request_check();
        check_pending = 1'b1;
        wait (check_pending == 1'b0);
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        test_errors_at_start = error_count;
    endtask

    task automatic end_test();
        test_count++;
        if (error_count != test_errors_at_start) failed_tests++;
        $display("test %0d %s: %s", test_count, test_name,
                 (error_count == test_errors_at_start) ? "ok" : "failed");
    endtask

    task automatic wait_output_equals(input string sig, input int value, input int limit);
        int cur;
        int n;
        cur = -1;
        n = 0;
        while (n < limit && cur != value) begin
            @(negedge clk_100mhz);
            if (sig == "running") begin
                cur = int'(running);
            end else if (sig == "bullet_count") begin
                cur = int'(bullet_count);
            end else begin
                cur = int'(target_count);
            end
            n++;
        end
        if (cur != value) begin
            $display("timeout after %0d cycles waiting for %s to reach %0d", limit, sig, value);
            error_count++;
        end
    endtask

    // 0 press, 1 move, 2 shoot
    task automatic pulse_button(input int which, input int gap);
        @(negedge clk_100mhz);
        case (which)
            0: press = 1'b1;
            1: move_btn = 1'b1;
            default: shoot_btn = 1'b1;
        endcase
        repeat (2) @(negedge clk_100mhz);
        press = 1'b0;
        move_btn = 1'b0;
        shoot_btn = 1'b0;
        repeat (gap) @(negedge clk_100mhz);
    endtask

    // direction settles through the synchronizer before the edge
    task automatic move_player(input logic [1:0] d);
        @(negedge clk_100mhz);
        dir_in = dir_t'(d);
        repeat (2) @(negedge clk_100mhz);
        pulse_button(1, 6);
    endtask

    task automatic spawn_target(input int x, input int y);
        @(negedge clk_100mhz);
        spawn_valid = 1'b1;
        spawn_x = coord_t'(x);
        spawn_y = coord_t'(y);
        @(negedge clk_100mhz);
        spawn_valid = 1'b0;
    endtask

    // target a few cells ahead of the muzzle, then one shot into it
    task automatic hit_target();
        int mx;
        int my;
        ref_step(ref_x, ref_y, ref_dir, 1'b1, mx, my);
        spawn_target(mx + 7, my - 1);
        exp_targets++;
        wait_output_equals("target_count", exp_targets, 4);
        pulse_button(2, 2);
        exp_targets--;
        exp_hits++;
        wait_output_equals("target_count", exp_targets, FLIGHT_CYCLES);
        wait_output_equals("bullet_count", 0, 4);
        request_check();
    endtask

    initial begin
        #(WATCHDOG_CYCLES * 10);
        $display("watchdog expired after %0d cycles, run did not finish", WATCHDOG_CYCLES);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        logic [1:0] d;
        void'($urandom(32'hbe3b_57ab));
        rst = 1'b1;
        press = 1'b0;
        move_btn = 1'b0;
        shoot_btn = 1'b0;
        dir_in = dir_right;
        spawn_valid = 1'b0;
        spawn_x = '0;
        spawn_y = '0;
        ref_x = 0;
        ref_y = 0;
        ref_dir = 2'd1;
        exp_running = 0;
        exp_bullets = 0;
        exp_targets = 0;
        exp_hits = 0;
        repeat (8) @(posedge clk_100mhz);
        @(negedge clk_100mhz);
        rst = 1'b0;

        begin_test("reset state and idle buttons");
        request_check();
        move_player(2'd3);
        pulse_button(2, 6);
        request_check();
        end_test();

        begin_test("random moves");
        pulse_button(0, 0);
        exp_running = 1;
        wait_output_equals("running", 1, 10);
        for (int i = 0; i < 40; i++) begin
            d = 2'($urandom % 4);
            ref_step(ref_x, ref_y, d, 1'b0, ref_x, ref_y);
            ref_dir = d;
            move_player(d);
            request_check();
        end
        end_test();

        begin_test("shot burst against credits");
        ref_step(ref_x, ref_y, 2'd1, 1'b0, ref_x, ref_y);
        ref_dir = 2'd1;
        move_player(2'd1);
        for (int i = 0; i < 16; i++) begin
            pulse_button(2, 2);
        end
        // twice as many shots as slots, none has left yet
        exp_bullets = `MAX_BULLETS;
        request_check();
        exp_bullets = 0;
        wait_output_equals("bullet_count", 0, FLIGHT_CYCLES);
        request_check();
        end_test();

        begin_test("single hit");
        hit_target();
        end_test();

        begin_test("score carry over ten hits");
        for (int i = 0; i < 9; i++) begin
            hit_target();
        end
        check_value("score", 16'(score), 16'h0010);
        end_test();

        begin_test("spawn into full target table");
        for (int i = 0; i <= `MAX_TARGETS; i++) begin
            spawn_target(20 + 5 * i, 40);
        end
        exp_targets = `MAX_TARGETS;
        @(negedge clk_100mhz);
        request_check();
        end_test();

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 test_count, failed_tests, check_count, error_count);
        if (error_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+design
design/grid_pkg.sv
design/bullet_pkg.sv
design/player_tank.sv
design/bullet_store.sv
design/bullet_stepper.sv
design/target_field.sv
design/tank_game_top.sv
test/tank_game_chk.sv
test/tank_game_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tank_game_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert --timescale 1ns/1ps

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Some tests failed" $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	fi
	@grep -q "All tests passed" $(LOG) || { echo "no pass result in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
